// File: int_exec.f
+incdir+logic
logic/exec_pkg.sv
logic/alu_fu.sv
logic/bru_fu.sv
logic/result_queue.sv
logic/exec_ctrl.sv
logic/int_exec.sv
tests/int_exec_checker.sv
tests/int_exec_tb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f int_exec.f --top-module int_exec_tb -o int_exec_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/int_exec_sim > sim.log 2>&1 || echo "simulator exited with an error"
cat sim.log
grep -q "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tests/int_exec_tb.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module int_exec_tb;

    localparam int MODE_ALU = 0;
    localparam int MODE_BR  = 1;
    localparam int MODE_MIX = 2;

    logic                   clk;
    logic                   rst;
    logic                   vld;
    exec_pkg::fu_info_t     fu_info;
    logic                   wb_stall;
    wire                    stall;
    wire exec_pkg::bypass_t bypass;
    wire                    wb_vld;
    wire exec_pkg::comwb_t  wb;
    wire                    redirect_vld;
    wire [`XLEN-1:0]        redirect_target;
    int                     err_cnt;
    int                     wb_cnt;
    int                     redirect_cnt;

    integer                 seed;
    logic [(1<<`ROB_W)-1:0] busy;       // accepted and not yet written back.
    logic [`ROB_W-1:0]      next_rob;
    logic                   accepted;
    logic                   stall_seen;
    logic                   timed_out;
    int                     issued;
    int                     total_ops;
    int                     stall_left;
    int                     tb_fails;
    int                     err_mark;

    int_exec UUT (
        .clk               (clk),
        .rst               (rst),
        .i_vld             (vld),
        .i_fu_info         (fu_info),
        .i_wb_stall        (wb_stall),
        .o_stall           (stall),
        .o_bypass          (bypass),
        .o_wb_vld          (wb_vld),
        .o_wb              (wb),
        .o_redirect_vld    (redirect_vld),
        .o_redirect_target (redirect_target)
    );

    int_exec_checker u_checker (
        .clk               (clk),
        .rst               (rst),
        .i_vld             (vld),
        .i_fu_info         (fu_info),
        .i_wb_stall        (wb_stall),
        .i_stall           (stall),
        .i_bypass          (bypass),
        .i_wb_vld          (wb_vld),
        .i_wb              (wb),
        .i_redirect_vld    (redirect_vld),
        .i_redirect_target (redirect_target),
        .o_err_cnt         (err_cnt),
        .o_wb_cnt          (wb_cnt),
        .o_redirect_cnt    (redirect_cnt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #20 clk = ~clk;
        end
    end

    task automatic pick_operand(output logic [`XLEN-1:0] val);
        int r;
        r = $random(seed);
        case (r[2:0])
            3'd0:    val = '0;
            3'd1:    val = '1;
            3'd2:    val = {1'b1, {(`XLEN-1){1'b0}}};
            3'd3:    val = `XLEN'h8000_0000;
            3'd4:    val = `XLEN'h7fff_ffff;
            default: val = {$random(seed), $random(seed)};
        endcase
    endtask

    task automatic gen_op(input int mode, output exec_pkg::fu_info_t op);
        int               r;
        int               r2;
        int               code;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        r  = $random(seed);
        r2 = $random(seed);
        case (mode)
            MODE_ALU: code = int'(r[7:0]) % 16;
            MODE_BR:  code = 16 + int'(r[7:0]) % 8;
            default:  code = int'(r[7:0]) % 24;
        endcase
        pick_operand(a);
        pick_operand(b);
        if (r[9:8] == 2'b00) begin
            b = a;
        end
        if (r[11:10] == 2'b00) begin
            b[5:0] = {r[13], {5{r[12]}}};   // 0, 31, 32 or 63.
        end
        op          = '0;
        op.mic_op   = exec_pkg::mic_op_t'(code[4:0]);
        op.rob_idx  = next_rob;
        op.iprd_idx = r[20:14];
        op.rd_wen   = (r[23:21] != 3'd0);
        op.srcs[0]  = a;
        op.srcs[1]  = b;
        op.pc       = {$random(seed), $random(seed)};
        op.pc[1:0]  = 2'b00;
        op.imm      = {{(`XLEN-32){r2[31]}}, r2};
    endtask

    // outputs settle by the falling edge.
    task automatic sample_cycle();
        @(negedge clk);
        if (wb_vld && !wb_stall) begin
            busy[wb.rob_idx] = 1'b0;
        end
        accepted = vld && !stall;
        if (accepted) begin
            busy[fu_info.rob_idx] = 1'b1;
            issued++;
        end
        stall_seen = stall_seen || stall;
        @(posedge clk);
    endtask

    task automatic run_ops(input int count, input int mode, input int level);
        exec_pkg::fu_info_t op;
        int                 r;
        int                 cycles;
        issued = 0;
        cycles = 0;
        while (issued < count && !timed_out) begin
            sample_cycle();
            r = $random(seed);
            if (!(vld && !accepted)) begin
                if (issued < count && !busy[next_rob] && r[2:0] != 3'd0) begin
                    gen_op(mode, op);
                    fu_info  <= op;
                    vld      <= 1'b1;
                    next_rob = next_rob + 1'b1;
                end else begin
                    vld <= 1'b0;
                end
            end
            if (level == 0) begin
                wb_stall <= 1'b0;
            end else if (stall_left > 0) begin
                wb_stall <= 1'b1;
                stall_left--;
            end else begin
                wb_stall <= (r[4:3] == 2'b00);
                if (level == 2 && r[9:5] == 5'd0) begin
                    stall_left = 24 + int'(r[14:10]);
                end
            end
            cycles++;
            if (cycles > count * 60 + 400) begin
                $display("timeout: only %0d of %0d ops were accepted", issued, count);
                timed_out = 1'b1;
            end
        end
        vld <= 1'b0;
        total_ops += issued;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while (busy != '0 && !timed_out) begin
            sample_cycle();
            wb_stall <= 1'b0;
            cycles++;
            if (cycles > 400) begin
                $display("timeout: %0d ops never wrote back", $countones(busy));
                timed_out = 1'b1;
            end
        end
        stall_left = 0;
        repeat (8) sample_cycle();   // late duplicates still get seen.
    endtask

    task automatic report_phase(input int num, input string name);
        $display("phase %0d %s done, errors %0d", num, name, err_cnt + tb_fails - err_mark);
        err_mark = err_cnt + tb_fails;
    endtask

    initial begin
        seed       = 83448;
        rst        = 1'b1;
        vld        = 1'b0;
        fu_info    = '0;
        wb_stall   = 1'b0;
        busy       = '0;
        next_rob   = '0;
        accepted   = 1'b0;
        stall_seen = 1'b0;
        timed_out  = 1'b0;
        total_ops  = 0;
        stall_left = 0;
        tb_fails   = 0;
        err_mark   = 0;
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        sample_cycle();
        sample_cycle();
        report_phase(1, "reset");
        run_ops(200, MODE_ALU, 0);
        wait_drain();
        report_phase(2, "alu ops");
        run_ops(150, MODE_BR, 0);
        wait_drain();
        report_phase(3, "branches and jumps");
        run_ops(200, MODE_MIX, 1);
        wait_drain();
        report_phase(4, "bypass");
        stall_seen = 1'b0;
        stall_left = 30;
        run_ops(300, MODE_MIX, 2);
        if (!stall_seen && !timed_out) begin
            $display("o_stall never rose while writeback was held back");
            tb_fails++;
        end
        wait_drain();
        report_phase(5, "writeback back-pressure");
        $display("summary: ops %0d, writebacks %0d, redirects %0d, errors %0d",
                 total_ops, wb_cnt, redirect_cnt, err_cnt + tb_fails);
        if (timed_out || err_cnt != 0 || tb_fails != 0) begin
            $display("TEST FAILED");
        end else begin
            $display("TEST OK");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/int_exec_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module int_exec_checker (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_vld,
    input  wire exec_pkg::fu_info_t i_fu_info,
    input  wire                     i_wb_stall,
    input  wire                     i_stall,
    input  wire exec_pkg::bypass_t  i_bypass,
    input  wire                     i_wb_vld,
    input  wire exec_pkg::comwb_t   i_wb,
    input  wire                     i_redirect_vld,
    input  wire [`XLEN-1:0]         i_redirect_target,
    output int                      o_err_cnt,
    output int                      o_wb_cnt,
    output int                      o_redirect_cnt
);

    localparam int ROB_N = 1 << `ROB_W;

    exec_pkg::branch_wb_t expect_tbl [ROB_N];
    logic [ROB_N-1:0]     pending;
    logic [ROB_N-1:0]     redirected;
    exec_pkg::branch_wb_t bp_exp;
    logic                 bp_due;
    logic                 held;
    exec_pkg::comwb_t     held_wb;
    logic                 was_rst;
    logic [`ROB_W-1:0]    rob;

    function automatic exec_pkg::branch_wb_t expected_result(input exec_pkg::fu_info_t op);
        exec_pkg::branch_wb_t r;
        logic [`XLEN-1:0]     a;
        logic [`XLEN-1:0]     b;
        logic [31:0]          w;
        r = '0;
        w = '0;
        a = op.srcs[0];
        b = op.srcs[1];
        r.wb.rob_idx  = op.rob_idx;
        r.wb.iprd_idx = op.iprd_idx;
        r.wb.rd_wen   = op.rd_wen;
        case (op.mic_op)
            exec_pkg::lui:    r.wb.result = op.imm;
            exec_pkg::add:    r.wb.result = a + b;
            exec_pkg::sub:    r.wb.result = a - b;
            exec_pkg::addw:   w = a[31:0] + b[31:0];
            exec_pkg::subw:   w = a[31:0] - b[31:0];
            exec_pkg::sll:    r.wb.result = a << b[5:0];
            exec_pkg::srl:    r.wb.result = a >> b[5:0];
            exec_pkg::sra:    r.wb.result = $signed(a) >>> b[5:0];
            exec_pkg::sllw:   w = a[31:0] << b[4:0];
            exec_pkg::srlw:   w = a[31:0] >> b[4:0];
            exec_pkg::sraw:   w = $signed(a[31:0]) >>> b[4:0];
            exec_pkg::op_xor: r.wb.result = a ^ b;
            exec_pkg::op_or:  r.wb.result = a | b;
            exec_pkg::op_and: r.wb.result = a & b;
            exec_pkg::slt:    r.wb.result = ($signed(a) < $signed(b)) ? `XLEN'd1 : `XLEN'd0;
            exec_pkg::sltu:   r.wb.result = (a < b) ? `XLEN'd1 : `XLEN'd0;
            exec_pkg::beq:    r.taken = (a == b);
            exec_pkg::bne:    r.taken = (a != b);
            exec_pkg::blt:    r.taken = ($signed(a) < $signed(b));
            exec_pkg::bge:    r.taken = ($signed(a) >= $signed(b));
            exec_pkg::bltu:   r.taken = (a < b);
            exec_pkg::bgeu:   r.taken = (a >= b);
            default:          r.taken = 1'b1;   // jal and jalr.
        endcase
        if (op.mic_op inside {exec_pkg::addw, exec_pkg::subw, exec_pkg::sllw,
                              exec_pkg::srlw, exec_pkg::sraw}) begin
            r.wb.result = {{(`XLEN-32){w[31]}}, w};
        end
        if (op.mic_op >= exec_pkg::beq) begin
            r.wb.result = op.pc + `XLEN'd4;   // link value.
            r.wb.rd_wen = op.rd_wen && (op.mic_op >= exec_pkg::jal);
            r.target    = (op.mic_op == exec_pkg::jalr) ? ((a + op.imm) & ~`XLEN'd1)
                                                        : (op.pc + op.imm);
        end
        return r;
    endfunction

    initial begin
        o_err_cnt      = 0;
        o_wb_cnt       = 0;
        o_redirect_cnt = 0;
        pending        = '0;
        redirected     = '0;
        bp_due         = 1'b0;
        held           = 1'b0;
        was_rst        = 1'b0;
        forever begin
            @(negedge clk);
            if (rst || was_rst) begin
                if (i_wb_vld || i_redirect_vld || i_bypass.vld || i_stall) begin
                    $display("error %0t: outputs active around reset (wb %0b redir %0b bp %0b stall %0b)",
                             $time, i_wb_vld, i_redirect_vld, i_bypass.vld, i_stall);
                    o_err_cnt++;
                end
            end
            was_rst = rst;
            if (!rst) begin
                if (bp_due) begin
                    if (bp_exp.wb.rd_wen && (!i_bypass.vld || i_bypass.iprd_idx !== bp_exp.wb.iprd_idx
                                             || i_bypass.data !== bp_exp.wb.result)) begin
                        $display("error %0t: bypass prd %0d data %h vld %0b, expected prd %0d data %h",
                                 $time, i_bypass.iprd_idx, i_bypass.data, i_bypass.vld,
                                 bp_exp.wb.iprd_idx, bp_exp.wb.result);
                        o_err_cnt++;
                    end else if (!bp_exp.wb.rd_wen && i_bypass.vld) begin
                        $display("error %0t: bypass valid for an op without a register write", $time);
                        o_err_cnt++;
                    end
                end
                if (held && (!i_wb_vld || i_wb !== held_wb)) begin
                    $display("error %0t: writeback record changed while stalled", $time);
                    o_err_cnt++;
                end
                rob = i_wb.rob_idx;
                if (i_redirect_vld) begin
                    if (!i_wb_vld || !pending[rob] || !expect_tbl[rob].taken || redirected[rob]) begin
                        $display("error %0t: unexpected redirect with rob %0d", $time, rob);
                        o_err_cnt++;
                    end else if (i_redirect_target !== expect_tbl[rob].target) begin
                        $display("error %0t: rob %0d redirect target %h, expected %h",
                                 $time, rob, i_redirect_target, expect_tbl[rob].target);
                        o_err_cnt++;
                    end
                    redirected[rob] = 1'b1;
                    o_redirect_cnt++;
                end
                if (i_wb_vld && !i_wb_stall) begin
                    if (!pending[rob]) begin
                        $display("error %0t: writeback of rob %0d that is not outstanding", $time, rob);
                        o_err_cnt++;
                    end else begin
                        if (i_wb !== expect_tbl[rob].wb) begin
                            $display("error %0t: rob %0d wrote prd %0d wen %0b data %h, expected %0d %0b %h",
                                     $time, rob, i_wb.iprd_idx, i_wb.rd_wen, i_wb.result,
                                     expect_tbl[rob].wb.iprd_idx, expect_tbl[rob].wb.rd_wen,
                                     expect_tbl[rob].wb.result);
                            o_err_cnt++;
                        end
                        if (expect_tbl[rob].taken && !redirected[rob]) begin
                            $display("error %0t: taken branch rob %0d wrote back without redirect",
                                     $time, rob);
                            o_err_cnt++;
                        end
                        pending[rob] = 1'b0;
                        o_wb_cnt++;
                    end
                end
                held    = i_wb_vld && i_wb_stall;
                held_wb = i_wb;
                bp_due  = i_vld && !i_stall;   // accepted on the coming edge.
                if (bp_due) begin
                    rob             = i_fu_info.rob_idx;
                    expect_tbl[rob] = expected_result(i_fu_info);
                    bp_exp          = expect_tbl[rob];
                    pending[rob]    = 1'b1;
                    redirected[rob] = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: logic/int_exec.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module int_exec (
    input  wire                         clk,
    input  wire                         rst,
    input  wire                         i_vld,
    input  wire exec_pkg::fu_info_t     i_fu_info,
    input  wire                         i_wb_stall,
    output wire                         o_stall,
    output wire exec_pkg::bypass_t      o_bypass,
    output wire                         o_wb_vld,
    output wire exec_pkg::comwb_t       o_wb,
    output wire                         o_redirect_vld,
    output wire [`XLEN-1:0]             o_redirect_target
);

    wire                            alu_vld;
    wire                            bru_vld;
    wire                            alu_stall;
    wire                            bru_stall;
    wire exec_pkg::bypass_t         alu_bypass;
    wire exec_pkg::bypass_t         bru_bypass;
    wire                            alu_finished;
    wire                            bru_finished;
    wire exec_pkg::comwb_t          alu_comwb;
    wire exec_pkg::branch_wb_t      bru_wb;
    wire                            alu_pop;
    wire                            bru_pop;
    wire exec_pkg::comwb_t          alu_head;
    wire exec_pkg::branch_wb_t      bru_head;
    wire                            alu_empty;
    wire                            bru_empty;
    wire [$clog2(`RQ_DEPTH):0]      alu_free;
    wire [$clog2(`RQ_DEPTH):0]      bru_free;

    exec_ctrl u_ctrl (
        .clk               (clk),
        .rst               (rst),
        .i_vld             (i_vld),
        .i_fu_info         (i_fu_info),
        .i_alu_bypass      (alu_bypass),
        .i_bru_bypass      (bru_bypass),
        .i_alu_empty       (alu_empty),
        .i_alu_free        (alu_free),
        .i_alu_head        (alu_head),
        .i_bru_empty       (bru_empty),
        .i_bru_free        (bru_free),
        .i_bru_head        (bru_head),
        .i_wb_stall        (i_wb_stall),
        .o_alu_vld         (alu_vld),
        .o_bru_vld         (bru_vld),
        .o_alu_stall       (alu_stall),
        .o_bru_stall       (bru_stall),
        .o_stall           (o_stall),
        .o_bypass          (o_bypass),
        .o_alu_pop         (alu_pop),
        .o_bru_pop         (bru_pop),
        .o_wb_vld          (o_wb_vld),
        .o_wb              (o_wb),
        .o_redirect_vld    (o_redirect_vld),
        .o_redirect_target (o_redirect_target)
    );

    alu_fu u_alu (
        .clk        (clk),
        .rst        (rst),
        .i_vld      (alu_vld),
        .i_fu_info  (i_fu_info),
        .i_stall    (alu_stall),
        .o_bypass   (alu_bypass),
        .o_finished (alu_finished),
        .o_comwb    (alu_comwb)
    );

    bru_fu u_bru (
        .clk         (clk),
        .rst         (rst),
        .i_vld       (bru_vld),
        .i_fu_info   (i_fu_info),
        .i_stall     (bru_stall),
        .o_bypass    (bru_bypass),
        .o_finished  (bru_finished),
        .o_branch_wb (bru_wb)
    );

    result_queue #(.payload_t(exec_pkg::comwb_t)) u_alu_rq (
        .clk     (clk),
        .rst     (rst),
        .i_push  (alu_finished),
        .i_data  (alu_comwb),
        .i_pop   (alu_pop),
        .o_data  (alu_head),
        .o_empty (alu_empty),
        .o_free  (alu_free)
    );

    result_queue #(.payload_t(exec_pkg::branch_wb_t)) u_bru_rq (
        .clk     (clk),
        .rst     (rst),
        .i_push  (bru_finished),
        .i_data  (bru_wb),
        .i_pop   (bru_pop),
        .o_data  (bru_head),
        .o_empty (bru_empty),
        .o_free  (bru_free)
    );

endmodule

`default_nettype wire

// File: logic/exec_ctrl.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module exec_ctrl (
    input  wire                             clk,
    input  wire                             rst,
    input  wire                             i_vld,
    input  wire exec_pkg::fu_info_t         i_fu_info,
    input  wire exec_pkg::bypass_t          i_alu_bypass,
    input  wire exec_pkg::bypass_t          i_bru_bypass,
    input  wire                             i_alu_empty,
    input  wire [$clog2(`RQ_DEPTH):0]       i_alu_free,
    input  wire exec_pkg::comwb_t           i_alu_head,
    input  wire                             i_bru_empty,
    input  wire [$clog2(`RQ_DEPTH):0]       i_bru_free,
    input  wire exec_pkg::branch_wb_t       i_bru_head,
    input  wire                             i_wb_stall,
    output logic                            o_alu_vld,
    output logic                            o_bru_vld,
    output logic                            o_alu_stall,
    output logic                            o_bru_stall,
    output logic                            o_stall,
    output exec_pkg::bypass_t               o_bypass,
    output logic                            o_alu_pop,
    output logic                            o_bru_pop,
    output logic                            o_wb_vld,
    output exec_pkg::comwb_t                o_wb,
    output logic                            o_redirect_vld,
    output logic [`XLEN-1:0]                o_redirect_target
);

    logic               is_br;
    logic               slot_open;
    logic               wb_vld;
    exec_pkg::comwb_t   wb_rec;
    logic               redirect_vld;
    logic [`XLEN-1:0]   redirect_target;

    assign is_br = i_fu_info.mic_op inside {
        exec_pkg::beq, exec_pkg::bne, exec_pkg::blt, exec_pkg::bge,
        exec_pkg::bltu, exec_pkg::bgeu, exec_pkg::jal, exec_pkg::jalr
    };

    // leave room for the two ops a unit may still have in flight.
    assign o_alu_stall = (i_alu_free <= 2);
    assign o_bru_stall = (i_bru_free <= 2);
    assign o_stall     = o_alu_stall || o_bru_stall;

    // an op only reaches a unit on the edge it is accepted.
    assign o_alu_vld = i_vld && !is_br && !o_stall;
    assign o_bru_vld = i_vld && is_br && !o_stall;

    assign o_bypass = i_alu_bypass.vld ? i_alu_bypass : i_bru_bypass;

    // writeback slot takes a new record when empty or consumed.
    assign slot_open = !wb_vld || !i_wb_stall;
    assign o_bru_pop = slot_open && !i_bru_empty;
    assign o_alu_pop = slot_open && i_bru_empty && !i_alu_empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_vld       <= 1'b0;
            redirect_vld <= 1'b0;
        end else if (slot_open) begin
            wb_vld       <= !i_bru_empty || !i_alu_empty;
            redirect_vld <= o_bru_pop && i_bru_head.taken;
        end else begin
            redirect_vld <= 1'b0;   // one pulse per branch record.
        end
    end

    always_ff @(posedge clk) begin
        if (o_bru_pop) begin
            wb_rec          <= i_bru_head.wb;
            redirect_target <= i_bru_head.target;
        end else if (o_alu_pop) begin
            wb_rec <= i_alu_head;
        end
    end

    assign o_wb_vld          = wb_vld;
    assign o_wb              = wb_rec;
    assign o_redirect_vld    = redirect_vld;
    assign o_redirect_target = redirect_target;

endmodule

`default_nettype wire

// File: logic/result_queue.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module result_queue #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = `RQ_DEPTH
) (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_push,
    input  wire payload_t           i_data,
    input  wire                     i_pop,
    output payload_t                o_data,
    output logic                    o_empty,
    output logic [$clog2(DEPTH):0]  o_free
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH) + 1;

    payload_t           mem [DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]   count;
    logic               do_push;
    logic               do_pop;

    assign do_push = i_push && (count != CNT_W'(DEPTH));  // drop on full.
    assign do_pop  = i_pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    assign o_data  = mem[rd_ptr];   // head seen without a pop.
    assign o_empty = (count == '0);
    assign o_free  = CNT_W'(DEPTH) - count;

endmodule

`default_nettype wire

// File: logic/bru_fu.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module bru_fu (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_vld,
    input  wire exec_pkg::fu_info_t i_fu_info,
    input  wire                     i_stall,
    output exec_pkg::bypass_t       o_bypass,
    output logic                    o_finished,
    output exec_pkg::branch_wb_t    o_branch_wb
);

    logic                 s1_vld;
    exec_pkg::fu_info_t   s1_info;

    logic [`XLEN-1:0]     src0;
    logic [`XLEN-1:0]     src1;
    logic                 eq;
    logic                 lt;
    logic                 ltu;
    logic                 is_jump;
    logic                 taken;
    logic [`XLEN-1:0]     target;
    logic [`XLEN-1:0]     link;

    logic                 finished;
    exec_pkg::branch_wb_t branch_wb;

    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (!i_stall) begin
            s1_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            s1_info <= i_fu_info;
        end
    end

    assign src0    = s1_info.srcs[0];
    assign src1    = s1_info.srcs[1];
    assign eq      = (src0 == src1);
    assign lt      = ($signed(src0) < $signed(src1));
    assign ltu     = (src0 < src1);
    assign is_jump = (s1_info.mic_op == exec_pkg::jal) || (s1_info.mic_op == exec_pkg::jalr);
    assign link    = s1_info.pc + `XLEN'd4;

    always_comb begin
        case (s1_info.mic_op)
            exec_pkg::beq:  taken = eq;
            exec_pkg::bne:  taken = !eq;
            exec_pkg::blt:  taken = lt;
            exec_pkg::bge:  taken = !lt;
            exec_pkg::bltu: taken = ltu;
            exec_pkg::bgeu: taken = !ltu;
            exec_pkg::jal:  taken = 1'b1;
            exec_pkg::jalr: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
        if (s1_info.mic_op == exec_pkg::jalr) begin
            target = (src0 + s1_info.imm) & ~`XLEN'd1;   // jalr drops bit 0.
        end else begin
            target = s1_info.pc + s1_info.imm;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            finished <= 1'b0;
        end else if (i_stall) begin
            finished <= 1'b0;
        end else begin
            finished <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            branch_wb.wb.rob_idx  <= s1_info.rob_idx;
            branch_wb.wb.iprd_idx <= s1_info.iprd_idx;
            branch_wb.wb.rd_wen   <= s1_info.rd_wen && is_jump;  // only jumps link.
            branch_wb.wb.result   <= link;
            branch_wb.taken       <= taken;
            branch_wb.target      <= target;
        end
    end

    assign o_bypass = '{
        vld:      s1_vld && s1_info.rd_wen && is_jump,
        iprd_idx: s1_info.iprd_idx,
        data:     link
    };

    assign o_finished  = finished;
    assign o_branch_wb = branch_wb;

endmodule

`default_nettype wire

// File: logic/alu_fu.sv
`timescale 1ns/10ps
`default_nettype none
`include "exec_consts.svh"

module alu_fu (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     i_vld,
    input  wire exec_pkg::fu_info_t i_fu_info,
    input  wire                     i_stall,
    output exec_pkg::bypass_t       o_bypass,
    output logic                    o_finished,
    output exec_pkg::comwb_t        o_comwb
);

    function automatic logic [`XLEN-1:0] sext_w(input logic [31:0] val);
        return {{(`XLEN-32){val[31]}}, val};
    endfunction

    logic               s1_vld;
    exec_pkg::fu_info_t s1_info;

    logic [`XLEN-1:0]   src0;
    logic [`XLEN-1:0]   src1;
    logic [5:0]         shamt;
    logic [4:0]         shamt_w;
    logic [`XLEN-1:0]   sum;
    logic [`XLEN-1:0]   diff;
    logic [31:0]        sllw_lo;
    logic [31:0]        srlw_lo;
    logic [31:0]        sraw_lo;
    logic [`XLEN-1:0]   calc;

    logic               finished;
    exec_pkg::comwb_t   comwb;

    // stage 1 holds the issued op.
    always_ff @(posedge clk) begin
        if (rst) begin
            s1_vld <= 1'b0;
        end else if (!i_stall) begin
            s1_vld <= i_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            s1_info <= i_fu_info;
        end
    end

    assign src0    = s1_info.srcs[0];
    assign src1    = s1_info.srcs[1];
    assign shamt   = src1[5:0];
    assign shamt_w = src1[4:0];

    always_comb begin
        sum     = src0 + src1;
        diff    = src0 - src1;
        sllw_lo = src0[31:0] << shamt_w;
        srlw_lo = src0[31:0] >> shamt_w;     // zeros come in from bit 31.
        sraw_lo = $signed(src0[31:0]) >>> shamt_w;
        case (s1_info.mic_op)
            exec_pkg::lui:    calc = s1_info.imm;
            exec_pkg::add:    calc = sum;
            exec_pkg::sub:    calc = diff;
            exec_pkg::addw:   calc = sext_w(sum[31:0]);
            exec_pkg::subw:   calc = sext_w(diff[31:0]);
            exec_pkg::sll:    calc = src0 << shamt;
            exec_pkg::srl:    calc = src0 >> shamt;
            exec_pkg::sra:    calc = $signed(src0) >>> shamt;
            exec_pkg::sllw:   calc = sext_w(sllw_lo);
            exec_pkg::srlw:   calc = sext_w(srlw_lo);
            exec_pkg::sraw:   calc = sext_w(sraw_lo);
            exec_pkg::op_xor: calc = src0 ^ src1;
            exec_pkg::op_or:  calc = src0 | src1;
            exec_pkg::op_and: calc = src0 & src1;
            exec_pkg::slt:    calc = {{(`XLEN-1){1'b0}}, $signed(src0) < $signed(src1)};
            exec_pkg::sltu:   calc = {{(`XLEN-1){1'b0}}, src0 < src1};
            default:          calc = '0;
        endcase
    end

    // finished is a pulse so the queue takes each record once.
    always_ff @(posedge clk) begin
        if (rst) begin
            finished <= 1'b0;
        end else if (i_stall) begin
            finished <= 1'b0;
        end else begin
            finished <= s1_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_stall) begin
            comwb.rob_idx  <= s1_info.rob_idx;
            comwb.iprd_idx <= s1_info.iprd_idx;
            comwb.rd_wen   <= s1_info.rd_wen;
            comwb.result   <= calc;
        end
    end

    assign o_bypass = '{
        vld:      s1_vld && s1_info.rd_wen,
        iprd_idx: s1_info.iprd_idx,
        data:     calc
    };

    assign o_finished = finished;
    assign o_comwb    = comwb;

endmodule

`default_nettype wire

// File: logic/exec_pkg.sv
`default_nettype none
`include "exec_consts.svh"

package exec_pkg;

    typedef enum logic [4:0] {
        lui,
        add,
        sub,
        addw,
        subw,
        sll,
        srl,
        sra,
        sllw,
        srlw,
        sraw,
        op_xor,
        op_or,
        op_and,
        slt,
        sltu,
        beq,   // branch class starts here.
        bne,
        blt,
        bge,
        bltu,
        bgeu,
        jal,
        jalr
    } mic_op_t;

    typedef struct packed {
        mic_op_t                    mic_op;
        logic [`ROB_W-1:0]          rob_idx;
        logic [`PRD_W-1:0]          iprd_idx;
        logic                       rd_wen;
        logic [1:0][`XLEN-1:0]      srcs;    // srcs[0] is rs1.
        logic [`XLEN-1:0]           pc;
        logic [`XLEN-1:0]           imm;     // already sign extended.
    } fu_info_t;

    typedef struct packed {
        logic [`ROB_W-1:0]          rob_idx;
        logic [`PRD_W-1:0]          iprd_idx;
        logic                       rd_wen;
        logic [`XLEN-1:0]           result;
    } comwb_t;

    typedef struct packed {
        comwb_t                     wb;
        logic                       taken;
        logic [`XLEN-1:0]           target;
    } branch_wb_t;

    typedef struct packed {
        logic                       vld;
        logic [`PRD_W-1:0]          iprd_idx;
        logic [`XLEN-1:0]           data;
    } bypass_t;

endpackage

`default_nettype wire

// File: logic/exec_consts.svh
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// integer data path width.
`define XLEN 64

// physical register index width.
`define PRD_W 7

// reorder buffer index width.
`define ROB_W 5

// entries per result queue.
// keep at least 3 so a stalled unit can still drain its two stages.
`define RQ_DEPTH 4

`endif
